// ==== verilog/pixelDrawPkg.sv ====
//##########################################################
// pixel draw package
// width typedefs and default parameter values shared by
// the tile-map pixel generator
//##########################################################
`default_nettype none

package pixelDrawPkg;

    //######################################################
    // default parameter values
    //######################################################
    localparam int cVhaw       = 11;                // horizontal position width
    localparam int cVvaw       = 11;                // vertical position width
    localparam int cTileBits   = 4;                 // log2 tile edge, 16 px tiles
    localparam int cMapColBits = 5;                 // 32 map columns, wraps
    localparam int cMapRowBits = 5;                 // 32 map rows, wraps
    localparam int cColorBits  = 8;                 // colour index width
    localparam int cSpriteBits = 4;                 // log2 sprite edge

    //######################################################
    // width typedefs
    //######################################################
    typedef logic [cVhaw-1:0]      hPos_t;          // active-area column
    typedef logic [cVvaw-1:0]      vPos_t;          // active-area line
    typedef logic [cColorBits-1:0] tileCode_t;      // one map entry
    typedef logic [cColorBits-1:0] colorIdx_t;      // 0 is transparent for sprite

    // row bits on top, column bits below
    typedef logic [cMapRowBits+cMapColBits-1:0] mapAddr_t;

endpackage

`default_nettype wire

// ==== verilog/drawPosition.sv ====
//##########################################################
// draw position
// active-area column and line counters, wrapping at the
// last indices from software, plus tile coordinates and a
// frame-end pulse two pixels early
//##########################################################
`default_nettype none

module drawPosition #(
    parameter int pVhaw     = pixelDrawPkg::cVhaw,
    parameter int pVvaw     = pixelDrawPkg::cVvaw,
    parameter int pTileBits = pixelDrawPkg::cTileBits
) (
    input  wire logic                         iCLK,
    input  wire logic                         iRST,
    input  wire logic                         iCKE,       // pixel enable
    input  wire pixelDrawPkg::hPos_t          iVha,       // last active column
    input  wire pixelDrawPkg::vPos_t          iVva,       // last active line
    output pixelDrawPkg::hPos_t               hPos,
    output pixelDrawPkg::vPos_t               vPos,
    output logic [pVhaw-pTileBits-1:0]        hTile,      // coarse column
    output logic [pVvaw-pTileBits-1:0]        vTile,      // coarse line
    output logic                              feFast      // early frame end
);

    //######################################################
    // wrap detection
    //######################################################
    pixelDrawPkg::hPos_t hCnt;                            // column counter
    pixelDrawPkg::vPos_t vCnt;                            // line counter
    pixelDrawPkg::hPos_t hFast;                           // compare point for feFast
    logic                hLast;
    logic                vLast;

    assign hLast = (hCnt == iVha);                        // end of line
    assign vLast = (vCnt == iVva);                        // last line
    assign hFast = pixelDrawPkg::hPos_t'(iVha - 2'd2);    // two pixels before end

    //######################################################
    // counters and early frame end
    //######################################################
    always_ff @(posedge iCLK)
    begin
        if (iRST)
        begin
            hCnt   <= '0;
            vCnt   <= '0;
            feFast <= 1'b0;
        end
        else if (iCKE)
        begin
            if (hLast)
            begin
                hCnt <= '0;                               // wrap column
                if (vLast)
                    vCnt <= '0;                           // wrap frame
                else
                    vCnt <= pixelDrawPkg::vPos_t'(vCnt + 1'b1);
            end
            else
                hCnt <= pixelDrawPkg::hPos_t'(hCnt + 1'b1);
            feFast <= vLast && (hCnt == hFast);           // one-cycle pulse
        end
        else
            feFast <= 1'b0;                               // no pulse while stalled
    end

    assign hPos  = hCnt;
    assign vPos  = vCnt;
    assign hTile = hCnt[pVhaw-1:pTileBits];               // drop in-tile bits
    assign vTile = vCnt[pVvaw-1:pTileBits];

    // column stays in range as long as the wrap point holds still
    hPosInRange: assert property (@(posedge iCLK) disable iff (iRST)
        (hCnt <= iVha) ##1 $stable(iVha) |-> (hCnt <= iVha));

endmodule

`default_nettype wire

// ==== verilog/tileLayer.sv ====
//##########################################################
// tile layer
// writable 32x32 tile map looked up by tile coordinate,
// code shaded with a checker pattern inside each tile
//##########################################################
`default_nettype none

module tileLayer #(
    parameter int pVhaw       = pixelDrawPkg::cVhaw,
    parameter int pVvaw       = pixelDrawPkg::cVvaw,
    parameter int pTileBits   = pixelDrawPkg::cTileBits,
    parameter int pMapColBits = pixelDrawPkg::cMapColBits,
    parameter int pMapRowBits = pixelDrawPkg::cMapRowBits
) (
    input  wire logic                         iCLK,
    input  wire logic                         iRST,
    input  wire logic                         iCKE,
    input  wire pixelDrawPkg::hPos_t          hPos,
    input  wire pixelDrawPkg::vPos_t          vPos,
    input  wire logic [pVhaw-pTileBits-1:0]   hTile,
    input  wire logic [pVvaw-pTileBits-1:0]   vTile,
    input  wire logic                         mapWe,      // map write strobe
    input  wire pixelDrawPkg::mapAddr_t       mapAddr,
    input  wire pixelDrawPkg::tileCode_t      mapData,
    output pixelDrawPkg::colorIdx_t           bgColor
);

    localparam int cMapDepth = 1 << (pMapRowBits + pMapColBits);

    //######################################################
    // tile map
    //######################################################
    pixelDrawPkg::tileCode_t mapMem [cMapDepth];          // one code per tile
    pixelDrawPkg::mapAddr_t  rdAddr;
    pixelDrawPkg::tileCode_t tileCode;

    // writes land on any edge regardless of pixel enable
    always_ff @(posedge iCLK)
    begin
        if (mapWe)
            mapMem[mapAddr] <= mapData;
    end

    // map wraps every 32 tiles on both axes
    assign rdAddr   = {vTile[pMapRowBits-1:0], hTile[pMapColBits-1:0]};
    assign tileCode = mapMem[rdAddr];                     // read before the edge

    //######################################################
    // checker shading
    //######################################################
    logic shadeInv;

    assign shadeInv = hPos[pTileBits-1] ^ vPos[pTileBits-1]; // in-tile msbs

    always_ff @(posedge iCLK)
    begin
        if (iCKE)
        begin
            if (shadeInv)
                bgColor <= ~tileCode;                     // dark quadrant
            else
                bgColor <= tileCode;                      // plain quadrant
        end
    end

    // an unknown strobe would corrupt the map silently
    mapWeKnown: assert property (@(posedge iCLK) disable iff (iRST)
        !$isunknown(mapWe));

endmodule

`default_nettype wire

// ==== verilog/spriteLayer.sv ====
//##########################################################
// sprite layer
// hit test of the position against one solid square sprite
//##########################################################
`default_nettype none

module spriteLayer #(
    parameter int pVhaw       = pixelDrawPkg::cVhaw,
    parameter int pVvaw       = pixelDrawPkg::cVvaw,
    parameter int pSpriteBits = pixelDrawPkg::cSpriteBits
) (
    input  wire logic                         iCLK,
    input  wire logic                         iRST,
    input  wire logic                         iCKE,
    input  wire pixelDrawPkg::hPos_t          hPos,
    input  wire pixelDrawPkg::vPos_t          vPos,
    input  wire pixelDrawPkg::hPos_t          spriteX,    // left edge
    input  wire pixelDrawPkg::vPos_t          spriteY,    // top edge
    input  wire pixelDrawPkg::colorIdx_t      spriteColor,
    output logic                              sprHit,
    output pixelDrawPkg::colorIdx_t           sprColor
);

    //######################################################
    // hit test
    //######################################################
    logic [pVhaw-1:0] dx;                                 // offset from left edge
    logic [pVvaw-1:0] dy;                                 // offset from top edge
    logic             hitX;
    logic             hitY;

    assign dx   = hPos - spriteX;                         // negative wraps high
    assign dy   = vPos - spriteY;
    assign hitX = (dx[pVhaw-1:pSpriteBits] == '0);        // 0 <= dx < edge
    assign hitY = (dy[pVvaw-1:pSpriteBits] == '0);

    //######################################################
    // output registers
    //######################################################
    always_ff @(posedge iCLK)
    begin
        if (iRST)
            sprHit <= 1'b0;
        else if (iCKE)
            sprHit <= hitX && hitY;                       // inside the square
    end

    always_ff @(posedge iCLK)
    begin
        if (iCKE)
            sprColor <= spriteColor;                      // solid colour
    end

endmodule

`default_nettype wire

// ==== verilog/pixelMixer.sv ====
//##########################################################
// pixel mixer
// sprite over background with colour 0 transparent,
// plus valid tracking through the two pipeline stages
//##########################################################
`default_nettype none

module pixelMixer (
    input  wire logic                         iCLK,
    input  wire logic                         iRST,
    input  wire logic                         iCKE,
    input  wire pixelDrawPkg::colorIdx_t      bgColor,
    input  wire logic                         sprHit,
    input  wire pixelDrawPkg::colorIdx_t      sprColor,
    output pixelDrawPkg::colorIdx_t           pixel,
    output logic                              pixelValid
);

    logic layerValid;                                     // stage 1 holds real data
    logic sprOpaque;

    assign sprOpaque = sprHit && (sprColor != '0);        // sprite wins if opaque

    always_ff @(posedge iCLK)
    begin
        if (iCKE)
            pixel <= sprOpaque ? sprColor : bgColor;
    end

    // valid shift, high once both stages are filled
    always_ff @(posedge iCLK)
    begin
        if (iRST)
        begin
            layerValid <= 1'b0;
            pixelValid <= 1'b0;
        end
        else if (iCKE)
        begin
            layerValid <= 1'b1;                           // first advance done
            pixelValid <= layerValid;
        end
        else
            pixelValid <= 1'b0;                           // stalled cycle
    end

endmodule

`default_nettype wire

// ==== verilog/pixelDrawTop.sv ====
//##########################################################
// pixel draw top
// tile-map pixel generator, position counters feeding the
// background and sprite layers and the mixer
//##########################################################
`default_nettype none

module pixelDrawTop #(
    parameter int pVhaw       = pixelDrawPkg::cVhaw,
    parameter int pVvaw       = pixelDrawPkg::cVvaw,
    parameter int pTileBits   = pixelDrawPkg::cTileBits,
    parameter int pMapColBits = pixelDrawPkg::cMapColBits,
    parameter int pMapRowBits = pixelDrawPkg::cMapRowBits,
    parameter int pSpriteBits = pixelDrawPkg::cSpriteBits
) (
    input  wire logic                         iCLK,
    input  wire logic                         iRST,
    input  wire logic                         iCKE,       // pixel enable
    input  wire pixelDrawPkg::hPos_t          iVha,
    input  wire pixelDrawPkg::vPos_t          iVva,
    input  wire logic                         mapWe,
    input  wire pixelDrawPkg::mapAddr_t       mapAddr,
    input  wire pixelDrawPkg::tileCode_t      mapData,
    input  wire pixelDrawPkg::hPos_t          spriteX,
    input  wire pixelDrawPkg::vPos_t          spriteY,
    input  wire pixelDrawPkg::colorIdx_t      spriteColor,
    output pixelDrawPkg::colorIdx_t           pixel,
    output logic                              pixelValid,
    output logic                              feFast
);

    pixelDrawPkg::hPos_t              hPos;
    pixelDrawPkg::vPos_t              vPos;
    logic [pVhaw-pTileBits-1:0]       hTile;
    logic [pVvaw-pTileBits-1:0]       vTile;
    pixelDrawPkg::colorIdx_t          bgColor;
    logic                             sprHit;
    pixelDrawPkg::colorIdx_t          sprColor;

    drawPosition #(
        .pVhaw(pVhaw), .pVvaw(pVvaw), .pTileBits(pTileBits)
    ) drawPosition_i (
        .iCLK(iCLK), .iRST(iRST), .iCKE(iCKE),
        .iVha(iVha), .iVva(iVva),
        .hPos(hPos), .vPos(vPos), .hTile(hTile), .vTile(vTile),
        .feFast(feFast)
    );

    tileLayer #(
        .pVhaw(pVhaw), .pVvaw(pVvaw), .pTileBits(pTileBits),
        .pMapColBits(pMapColBits), .pMapRowBits(pMapRowBits)
    ) tileLayer_i (
        .iCLK(iCLK), .iRST(iRST), .iCKE(iCKE),
        .hPos(hPos), .vPos(vPos), .hTile(hTile), .vTile(vTile),
        .mapWe(mapWe), .mapAddr(mapAddr), .mapData(mapData),
        .bgColor(bgColor)
    );

    spriteLayer #(
        .pVhaw(pVhaw), .pVvaw(pVvaw), .pSpriteBits(pSpriteBits)
    ) spriteLayer_i (
        .iCLK(iCLK), .iRST(iRST), .iCKE(iCKE),
        .hPos(hPos), .vPos(vPos),
        .spriteX(spriteX), .spriteY(spriteY), .spriteColor(spriteColor),
        .sprHit(sprHit), .sprColor(sprColor)
    );

    pixelMixer pixelMixer_i (
        .iCLK(iCLK), .iRST(iRST), .iCKE(iCKE),
        .bgColor(bgColor), .sprHit(sprHit), .sprColor(sprColor),
        .pixel(pixel), .pixelValid(pixelValid)
    );

endmodule

`default_nettype wire

// ==== tests/tbClockGen.sv ====
//##########################################################
// testbench clock and reset
// free-running clock plus a synchronous reset pulse
//##########################################################
`default_nettype none

module tbClockGen #(
    parameter int pPeriod      = 8,                    // clock period in time units
    parameter int pResetCycles = 16                    // cycles with reset held
) (
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        forever #(pPeriod / 2) clk = ~clk;             // 50% duty
    end

    initial
    begin
        rst = 1'b1;
        repeat (pResetCycles) @(posedge clk);
        rst <= 1'b0;                                   // last reset edge still sees high
    end

endmodule

`default_nettype wire

// ==== tests/pixelDrawTb.sv ====
//##########################################################
// pixel draw testbench
// LFSR stimulus against a cycle model of position, layers
// and mixer, checked on every falling edge
//##########################################################
`default_nettype none

module pixelDrawTb;

    localparam int cVha    = 47;                       // 48 columns
    localparam int cVva    = 39;                       // 40 lines
    localparam int cFrame  = (cVha + 1) * (cVva + 1);  // advances per frame
    localparam int cEdge   = 1 << pixelDrawPkg::cSpriteBits;
    localparam int cTile   = 1 << pixelDrawPkg::cTileBits;
    localparam int cFill   = 1024;
    localparam int cTotal  = 16 + cFill + 3 * cFrame + 2 * cFrame + 4 * cFrame + 8 * cFrame;
    localparam int cTimeout = 2 * cTotal;

    logic iCLK, iRST, iCKE, mapWe, pixelValid, feFast;
    pixelDrawPkg::hPos_t      iVha, spriteX;
    pixelDrawPkg::vPos_t      iVva, spriteY;
    pixelDrawPkg::mapAddr_t   mapAddr;
    pixelDrawPkg::tileCode_t  mapData;
    pixelDrawPkg::colorIdx_t  spriteColor, pixel;

    tbClockGen #(.pPeriod(8), .pResetCycles(16)) clockGen_i (.clk(iCLK), .rst(iRST));

    pixelDrawTop dut_i (
        .iCLK(iCLK), .iRST(iRST), .iCKE(iCKE), .iVha(iVha), .iVva(iVva),
        .mapWe(mapWe), .mapAddr(mapAddr), .mapData(mapData),
        .spriteX(spriteX), .spriteY(spriteY), .spriteColor(spriteColor),
        .pixel(pixel), .pixelValid(pixelValid), .feFast(feFast)
    );

    //######################################################
    // model state
    //######################################################
    pixelDrawPkg::tileCode_t mapM [1024];              // shadow of the tile map
    pixelDrawPkg::colorIdx_t s1Bg, s1Spr, pixExp;      // layer stage and mixer stage
    logic        s1Hit = 1'b0, s1Val = 1'b0, valExp = 1'b0, feExp = 1'b0;
    int          hM = 0, vM = 0;                       // model position
    int          advances = 0, lastFe = -1, feCount = 0, sprPixels = 0;
    int          errors = 0, checks = 0, cycleCount = 0;
    logic [31:0] lfsr = 32'hc8fe_ce7c;

    // taps 32 22 2 1 with one step per bit taken
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // map entry of one of the 3x3 tiles that the frame shows
    function automatic pixelDrawPkg::mapAddr_t pickVisibleAddr();
        logic [31:0] row;
        logic [31:0] col;
        row = takeBits(2) % 3;
        col = takeBits(2) % 3;
        return pixelDrawPkg::mapAddr_t'({row[4:0], col[4:0]});
    endfunction

    task automatic randomSprite(input logic opaque);
        spriteX     = pixelDrawPkg::hPos_t'(takeBits(6));   // may hang off the frame
        spriteY     = pixelDrawPkg::vPos_t'(takeBits(6));
        spriteColor = pixelDrawPkg::colorIdx_t'(takeBits(8));
        if (!opaque)
            spriteColor = '0;
        else if (spriteColor == '0)
            spriteColor = pixelDrawPkg::colorIdx_t'(1);
    endtask

    task automatic reportMismatch(input string testName, input string what,
                                  input logic [31:0] expected, input logic [31:0] actual);
        errors++;
        $display("FAILED %s %s expected %0h actual %0h", testName, what, expected, actual);
    endtask

    task automatic checkOutputs(input string testName);
        checks++;
        assert (pixelValid === valExp)
            else reportMismatch(testName, "pixelValid", 32'(valExp), 32'(pixelValid));
        assert (feFast === feExp)
            else reportMismatch(testName, "feFast", 32'(feExp), 32'(feFast));
        if (valExp)
        begin
            assert (pixel === pixExp)
                else reportMismatch(testName, "pixel", 32'(pixExp), 32'(pixel));
        end
        if (feFast === 1'b1)
        begin
            feCount++;
            if (lastFe >= 0)
            begin
                assert (advances - lastFe == cFrame)
                    else reportMismatch(testName, "frame spacing", 32'(cFrame),
                                        32'(advances - lastFe));
            end
            lastFe = advances;
        end
    endtask

    //######################################################
    // one clock of drive, model step and check after the edge
    //######################################################
    task automatic runCycle(input logic cke, input logic we, input pixelDrawPkg::mapAddr_t addr,
                            input pixelDrawPkg::tileCode_t data, input string testName);
        int idx;
        pixelDrawPkg::tileCode_t code;
        iCKE    = cke;
        mapWe   = we;
        mapAddr = addr;
        mapData = data;
        if (cke)
        begin
            if (s1Hit && (s1Spr != '0))
                pixExp = s1Spr;                        // opaque sprite on top
            else
                pixExp = s1Bg;
            if (s1Val && s1Hit && (s1Spr != '0))
                sprPixels++;
            valExp = s1Val;
            s1Val  = 1'b1;
            idx    = ((vM / cTile) % 32) * 32 + (hM / cTile) % 32;
            code   = mapM[idx];                        // old contents on a write edge
            s1Bg   = ((((hM / 8) ^ (vM / 8)) % 2) != 0) ? ~code : code;
            s1Hit  = (hM >= int'(spriteX)) && (hM < int'(spriteX) + cEdge) &&
                     (vM >= int'(spriteY)) && (vM < int'(spriteY) + cEdge);
            s1Spr  = spriteColor;
            feExp  = (vM == cVva) && (hM == cVha - 2);
            advances++;
            if (hM == cVha)
            begin
                hM = 0;
                vM = (vM == cVva) ? 0 : vM + 1;
            end
            else
                hM++;
        end
        else
        begin
            valExp = 1'b0;                             // stalled cycle
            feExp  = 1'b0;
        end
        if (we)
            mapM[addr] = data;
        @(negedge iCLK);
        checkOutputs(testName);
    endtask

    //######################################################
    // test sequence
    //######################################################
    initial
    begin
        iCKE = 1'b0;
        mapWe = 1'b0;
        mapAddr = '0;
        mapData = '0;
        iVha = pixelDrawPkg::hPos_t'(cVha);
        iVva = pixelDrawPkg::vPos_t'(cVva);
        spriteX = '0;
        spriteY = '0;
        spriteColor = '0;                              // sprite transparent at first
        for (int a = 0; a < 1024; a++)
            mapM[a] = '0;
        wait (!iRST);
        @(negedge iCLK);
        for (int a = 0; a < cFill; a++)                // whole map while counters stay frozen
            runCycle(1'b0, 1'b1, pixelDrawPkg::mapAddr_t'(a),
                     pixelDrawPkg::tileCode_t'(takeBits(8)), "mapFill");
        feCount = 0;
        for (int i = 0; i < 3 * cFrame; i++)           // wrap and shading
            runCycle(1'b1, 1'b0, '0, '0, "positionWrap");
        assert (feCount == 3)
            else reportMismatch("positionWrap", "frame-end pulses", 32'd3, 32'(feCount));
        for (int i = 0; i < 2 * cFrame; i++)
            runCycle(1'b1, (takeBits(3) == 0), pickVisibleAddr(),
                     pixelDrawPkg::tileCode_t'(takeBits(8)), "liveMapUpdate");
        for (int k = 0; k < 16; k++)
        begin
            randomSprite(k % 4 != 3);                  // every fourth one transparent
            for (int i = 0; i < cFrame / 4; i++)
                runCycle(1'b1, 1'b0, '0, '0, "spriteOverlay");
        end
        assert (sprPixels > 0)
        else
        begin
            errors++;
            $display("spriteOverlay never drew a sprite pixel");
        end
        for (int i = 0; i < 8 * cFrame; i++)
        begin
            if (takeBits(8) == 0)
                randomSprite(1'b1);
            runCycle((takeBits(1) != 0), (takeBits(3) == 0), pickVisibleAddr(),
                     pixelDrawPkg::tileCode_t'(takeBits(8)), "pixelStall");
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    // watchdog sized from the phase lengths
    always @(posedge iCLK)
    begin
        cycleCount++;
        if (cycleCount > cTimeout)
        begin
            $display("timeout, run did not finish within %0d cycles", cTimeout);
            $display("STATUS: FAIL");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== pixelDrawTop.f ====
verilog/pixelDrawPkg.sv
verilog/drawPosition.sv
verilog/tileLayer.sv
verilog/spriteLayer.sv
verilog/pixelMixer.sv
verilog/pixelDrawTop.sv
tests/tbClockGen.sv
tests/pixelDrawTb.sv

// ==== Makefile ====
# Verilator build and run for the tile-map pixel generator

VERILATOR ?= verilator
TOP       ?= pixelDrawTb
FLIST     ?= pixelDrawTop.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell cat $(FLIST))
SIM  := $(BUILD_DIR)/$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR) -o $(TOP)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then echo "no status line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
